// ==== verilog/gb_timer_pkg.sv ====
package gb_timer_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  typedef logic [15:0] bus_addr_t;
  typedef logic [7:0]  reg_byte_t;
  // Internal divider, upper byte seen as DIV
  typedef logic [15:0] div_count_t;

  // T-cycle phases of one machine cycle
  typedef enum logic [1:0] {
    T1 = 2'd0,
    T2 = 2'd1,
    T3 = 2'd2,
    T4 = 2'd3
  } t_phase_t;

  // ==========================================================================
  // Register map and constants
  // ==========================================================================
  localparam bus_addr_t  ADDR_DIV        = 16'hFF04;
  localparam bus_addr_t  ADDR_TIMA       = 16'hFF05;
  localparam bus_addr_t  ADDR_TMA        = 16'hFF06;
  localparam bus_addr_t  ADDR_TAC        = 16'hFF07;
  localparam bus_addr_t  ADDR_IF         = 16'hFF0F;
  // Unused upper bits read as ones
  localparam reg_byte_t  TAC_FIXED_ONES  = 8'hF8;
  localparam reg_byte_t  IF_FIXED_ONES   = 8'hE0;
  localparam div_count_t DIV_WRITE_VALUE = 16'd4;
  localparam int         TIMER_IRQ_BIT   = 2;
  localparam reg_byte_t  READ_IDLE       = 8'hFF;

endpackage

// ==== verilog/t_phase_sequencer.sv ====
`timescale 1ns/1ps

module t_phase_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  output gb_timer_pkg::t_phase_t t_phase
);
  import gb_timer_pkg::*;

  t_phase_t next_phase;

  // Fixed rotation through the machine cycle
  always_comb begin
    unique case (t_phase)
      T1:      next_phase = T2;
      T2:      next_phase = T3;
      T3:      next_phase = T4;
      T4:      next_phase = T1;
      default: next_phase = T1;
    endcase
  end

  // First cycle after reset is T1
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      t_phase <= T1;
    end else begin
      t_phase <= next_phase;
    end
  end

  // Whole machine cycle runs in order once started at T1
  phase_order: assert property (@(posedge clk) disable iff (reset)
    t_phase == T1 |=> t_phase == T2 ##1 t_phase == T3 ##1 t_phase == T4 ##1 t_phase == T1);

endmodule

// ==== verilog/timer_reg_decode.sv ====
`timescale 1ns/1ps

module timer_reg_decode (
  input  gb_timer_pkg::bus_addr_t addr,
  input  logic                    read_en,
  input  logic                    write_en,
  input  gb_timer_pkg::reg_byte_t div_high,
  input  gb_timer_pkg::reg_byte_t tima,
  input  gb_timer_pkg::reg_byte_t tma,
  input  gb_timer_pkg::reg_byte_t tac,
  input  gb_timer_pkg::reg_byte_t if_flags,
  output logic                    div_wr,
  output logic                    tima_wr,
  output logic                    tma_wr,
  output logic                    tac_wr,
  output logic                    if_wr,
  output gb_timer_pkg::reg_byte_t rdata
);
  import gb_timer_pkg::*;

  logic div_sel;
  logic tima_sel;
  logic tma_sel;
  logic tac_sel;
  logic if_sel;

  // ==========================================================================
  // Address match
  // ==========================================================================
  assign div_sel  = (addr == ADDR_DIV);
  assign tima_sel = (addr == ADDR_TIMA);
  assign tma_sel  = (addr == ADDR_TMA);
  assign tac_sel  = (addr == ADDR_TAC);
  assign if_sel   = (addr == ADDR_IF);

  // Write strobes, one cycle wide with the bus write
  assign div_wr  = write_en & div_sel;
  assign tima_wr = write_en & tima_sel;
  assign tma_wr  = write_en & tma_sel;
  assign tac_wr  = write_en & tac_sel;
  assign if_wr   = write_en & if_sel;

  // ==========================================================================
  // Read mux
  // ==========================================================================
  // Same-cycle return, idle value when nothing matches
  always_comb begin
    rdata = READ_IDLE;
    if (read_en) begin
      if (div_sel)       rdata = div_high;
      else if (tima_sel) rdata = tima;
      else if (tma_sel)  rdata = tma;
      else if (tac_sel)  rdata = tac;
      else if (if_sel)   rdata = if_flags;
    end
  end

  // Core and flag register never see two writes at once
  strobe_onehot: assert final ($onehot0({div_wr, tima_wr, tma_wr, tac_wr, if_wr}));

endmodule

// ==== verilog/timer_core.sv ====
`timescale 1ns/1ps

module timer_core (
  input  logic                    clk,
  input  logic                    reset,
  input  gb_timer_pkg::t_phase_t  t_phase,
  input  logic                    div_wr,
  input  logic                    tima_wr,
  input  logic                    tma_wr,
  input  logic                    tac_wr,
  input  gb_timer_pkg::reg_byte_t wdata,
  output gb_timer_pkg::reg_byte_t div_high,
  output gb_timer_pkg::reg_byte_t tima,
  output gb_timer_pkg::reg_byte_t tma,
  output gb_timer_pkg::reg_byte_t tac,
  output logic                    timer_req
);
  import gb_timer_pkg::*;

  // Free-running divider, one count per t-cycle
  div_count_t div_count;

  logic sel_bit;
  logic sel_bit_prev;
  logic tick;
  logic pending;
  logic timer_write;

  // CPU sees only the top byte
  assign div_high = div_count[15:8];

  // Any timer register write freezes counting for that cycle
  assign timer_write = div_wr | tima_wr | tma_wr | tac_wr;

  // ==========================================================================
  // Tick source
  // ==========================================================================
  // Enable gates the bit before edge detection
  // so clearing TAC[2] can itself produce a tick
  always_comb begin
    unique case (tac[1:0])
      2'b00: sel_bit = div_count[9] & tac[2];
      2'b01: sel_bit = div_count[3] & tac[2];
      2'b10: sel_bit = div_count[5] & tac[2];
      2'b11: sel_bit = div_count[7] & tac[2];
      default: sel_bit = 1'b0;
    endcase
  end

  // Falling edge against last counted cycle
  assign tick = sel_bit_prev & ~sel_bit;

  // ==========================================================================
  // Registers
  // ==========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_count    <= '0;
      tima         <= '0;
      tma          <= '0;
      tac          <= TAC_FIXED_ONES;
      sel_bit_prev <= 1'b0;
      pending      <= 1'b0;
      timer_req    <= 1'b0;
    end else begin
      // Request is a single-cycle pulse
      timer_req <= 1'b0;

      // CPU writes
      if (div_wr)  div_count <= DIV_WRITE_VALUE;
      if (tima_wr) tima <= wdata;
      if (tma_wr)  tma <= wdata;
      if (tac_wr)  tac <= wdata | TAC_FIXED_ONES;

      // Counting only in cycles without a write
      if (!timer_write) begin
        div_count    <= div_count + 16'd1;
        sel_bit_prev <= sel_bit;

        // Delayed reload waits for start of machine cycle
        if (pending && t_phase == T1) begin
          pending   <= 1'b0;
          tima      <= tma;
          timer_req <= 1'b1;
        end else if (tick) begin
          if (tima == 8'hFF) begin
            // Reads 00 until reload
            tima    <= 8'h00;
            pending <= 1'b1;
          end else begin
            tima <= tima + 8'h01;
          end
        end
      end
    end
  end

  // Reload clears pending, so no back-to-back request
  req_single_cycle: assert property (@(posedge clk) disable iff (reset)
    timer_req |=> !timer_req);

  // Registered pulse, so the edge that raised it sampled T1
  req_on_t1: assert property (@(posedge clk) disable iff (reset)
    $rose(timer_req) |-> $past(t_phase) == T1);

endmodule

// ==== verilog/timer_interrupt_flag.sv ====
`timescale 1ns/1ps

module timer_interrupt_flag (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    timer_req,
  input  logic                    if_wr,
  input  gb_timer_pkg::reg_byte_t wdata,
  output gb_timer_pkg::reg_byte_t if_flags,
  output logic                    timer_irq
);
  import gb_timer_pkg::*;

  // Five request bits from VBlank to joypad
  logic [4:0] flags;

  // ==========================================================================
  // Flag register
  // ==========================================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else begin
      // CPU write replaces all five bits
      if (if_wr) begin
        flags <= wdata[4:0];
      end
      // Hardware request beats a same-cycle clear
      if (timer_req) begin
        flags[TIMER_IRQ_BIT] <= 1'b1;
      end
    end
  end

  // Upper three bits always read as ones
  assign if_flags = {IF_FIXED_ONES[7:5], flags};

  // Level until software clears it
  assign timer_irq = flags[TIMER_IRQ_BIT];

  // Core pulse lands in the flag one cycle later even under a CPU write
  irq_follows_req: assert property (@(posedge clk) disable iff (reset)
    timer_req |=> timer_irq);

endmodule

// ==== verilog/timer_subsystem.sv ====
`timescale 1ns/1ps

module timer_subsystem (
  input  logic                    clk,
  input  logic                    reset,
  input  gb_timer_pkg::bus_addr_t addr,
  input  logic                    read_en,
  input  logic                    write_en,
  input  gb_timer_pkg::reg_byte_t wdata,
  output gb_timer_pkg::reg_byte_t rdata,
  output logic                    timer_irq
);
  import gb_timer_pkg::*;

  t_phase_t  t_phase;
  logic      div_wr;
  logic      tima_wr;
  logic      tma_wr;
  logic      tac_wr;
  logic      if_wr;
  reg_byte_t div_high;
  reg_byte_t tima;
  reg_byte_t tma;
  reg_byte_t tac;
  reg_byte_t if_flags;
  logic      timer_req;

  // ==========================================================================
  // Phase, decode, core, flag
  // ==========================================================================
  t_phase_sequencer t_phase_sequencer_inst (
    .clk(clk), .reset(reset), .t_phase(t_phase)
  );

  // Bus side
  timer_reg_decode timer_reg_decode_inst (
    .addr(addr), .read_en(read_en), .write_en(write_en),
    .div_high(div_high), .tima(tima), .tma(tma), .tac(tac), .if_flags(if_flags),
    .div_wr(div_wr), .tima_wr(tima_wr), .tma_wr(tma_wr), .tac_wr(tac_wr),
    .if_wr(if_wr), .rdata(rdata)
  );

  timer_core timer_core_inst (
    .clk(clk), .reset(reset), .t_phase(t_phase),
    .div_wr(div_wr), .tima_wr(tima_wr), .tma_wr(tma_wr), .tac_wr(tac_wr),
    .wdata(wdata), .div_high(div_high), .tima(tima), .tma(tma), .tac(tac),
    .timer_req(timer_req)
  );

  // Interrupt request latch
  timer_interrupt_flag timer_interrupt_flag_inst (
    .clk(clk), .reset(reset), .timer_req(timer_req), .if_wr(if_wr),
    .wdata(wdata), .if_flags(if_flags), .timer_irq(timer_irq)
  );

endmodule

// ==== dv/timer_subsystem_tb.sv ====
`timescale 1ns/1ps

module timer_subsystem_tb;
  import gb_timer_pkg::*;

  // ==========================================================================
  // Test lengths and run limit
  // ==========================================================================
  localparam int RESET_CYCLES = 2;
  localparam int SMOKE_CYCLES = 8;
  localparam int DIV_CYCLES   = 2000;
  // Longer than one full period of the slowest rate
  localparam int RATE_CYCLES  = 1100;
  localparam int DROP_CYCLES  = 48;
  localparam int OVF_CYCLES   = 100;
  localparam int MIX_CYCLES   = 6000;
  localparam int TEST_CYCLES  = RESET_CYCLES + SMOKE_CYCLES + DIV_CYCLES
                              + 8 * (RATE_CYCLES + 2) + DROP_CYCLES
                              + 5 * (OVF_CYCLES + 5) + MIX_CYCLES;
  localparam int CYCLE_LIMIT  = TEST_CYCLES + 100;

  logic      clk;
  logic      reset;
  bus_addr_t addr;
  logic      read_en;
  logic      write_en;
  reg_byte_t wdata;
  reg_byte_t rdata;
  logic      timer_irq;

  int unsigned seed = 91;
  int          cycle_count = 0;

  // Reference model state, as seen during the current cycle
  t_phase_t   model_phase;
  div_count_t model_div;
  reg_byte_t  model_tima;
  reg_byte_t  model_tma;
  reg_byte_t  model_tac;
  logic       model_prev;
  logic       model_pending;
  logic       model_req;
  logic [4:0] model_flags;

  timer_subsystem timer_subsystem_inst (
    .clk(clk), .reset(reset), .addr(addr), .read_en(read_en), .write_en(write_en),
    .wdata(wdata), .rdata(rdata), .timer_irq(timer_irq)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // Hang guard
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  // ==========================================================================
  // Random source and stimulus picks
  // ==========================================================================
  function automatic logic [15:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[31:16];
  endfunction

  // Mostly timer registers, now and then anywhere in the map
  function automatic bus_addr_t pick_addr();
    logic [15:0] r;
    r = next_random();
    if (r[3:0] >= 4'd14) return next_random();
    case (r[3:0] % 4'd5)
      4'd0:    return ADDR_DIV;
      4'd1:    return ADDR_TIMA;
      4'd2:    return ADDR_TMA;
      4'd3:    return ADDR_TAC;
      default: return ADDR_IF;
    endcase
  endfunction

  // ==========================================================================
  // Cycle model
  // ==========================================================================
  task automatic model_reset();
    model_phase   = T1;
    model_div     = '0;
    model_tima    = 8'h00;
    model_tma     = 8'h00;
    model_tac     = 8'hF8;
    model_prev    = 1'b0;
    model_pending = 1'b0;
    model_req     = 1'b0;
    model_flags   = 5'b0;
  endtask

  function automatic reg_byte_t model_read(bus_addr_t a, logic rd);
    reg_byte_t v;
    v = 8'hFF;
    if (rd) begin
      case (a)
        16'hFF04: v = model_div[15:8];
        16'hFF05: v = model_tima;
        16'hFF06: v = model_tma;
        16'hFF07: v = model_tac;
        16'hFF0F: v = {3'b111, model_flags};
        default:  v = 8'hFF;
      endcase
    end
    return v;
  endfunction

  // One rising edge with the given bus write
  task automatic model_step(bus_addr_t a, logic wr, reg_byte_t d);
    logic       div_w;
    logic       tima_w;
    logic       tma_w;
    logic       tac_w;
    logic       if_w;
    logic       frozen;
    logic       sel;
    logic       tick;
    div_count_t n_div;
    reg_byte_t  n_tima;
    reg_byte_t  n_tma;
    reg_byte_t  n_tac;
    logic       n_prev;
    logic       n_pending;
    logic       n_req;
    logic [4:0] n_flags;
    div_w  = wr && (a == 16'hFF04);
    tima_w = wr && (a == 16'hFF05);
    tma_w  = wr && (a == 16'hFF06);
    tac_w  = wr && (a == 16'hFF07);
    if_w   = wr && (a == 16'hFF0F);
    frozen = div_w | tima_w | tma_w | tac_w;
    // Rate select 00/01/10/11 -> bit 9/3/5/7
    case (model_tac[1:0])
      2'b00:   sel = model_div[9];
      2'b01:   sel = model_div[3];
      2'b10:   sel = model_div[5];
      default: sel = model_div[7];
    endcase
    sel  = sel & model_tac[2];
    tick = model_prev & ~sel;
    n_div     = model_div;
    n_tima    = model_tima;
    n_tma     = model_tma;
    n_tac     = model_tac;
    n_prev    = model_prev;
    n_pending = model_pending;
    n_req     = 1'b0;
    if (div_w)  n_div = 16'd4;
    if (tima_w) n_tima = d;
    if (tma_w)  n_tma = d;
    if (tac_w)  n_tac = d | 8'hF8;
    if (!frozen) begin
      n_div  = model_div + 16'd1;
      n_prev = sel;
      if (model_pending && model_phase == T1) begin
        n_pending = 1'b0;
        n_tima    = model_tma;
        n_req     = 1'b1;
      end else if (tick) begin
        if (model_tima == 8'hFF) begin
          n_tima    = 8'h00;
          n_pending = 1'b1;
        end else begin
          n_tima = model_tima + 8'h01;
        end
      end
    end
    // Request outranks a same-cycle flag write
    n_flags = model_flags;
    if (if_w) n_flags = d[4:0];
    if (model_req) n_flags[2] = 1'b1;
    model_div     = n_div;
    model_tima    = n_tima;
    model_tma     = n_tma;
    model_tac     = n_tac;
    model_prev    = n_prev;
    model_pending = n_pending;
    model_req     = n_req;
    model_flags   = n_flags;
    model_phase   = t_phase_t'(model_phase + 2'd1);
  endtask

  // ==========================================================================
  // Checks and bus cycle
  // ==========================================================================
  task automatic compare_byte(string name, reg_byte_t expected, reg_byte_t actual);
    if (actual !== expected) begin
      $display("ERROR time=%0t %s expected=%02h actual=%02h", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic compare_irq(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("ERROR time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Called at a falling edge, returns at the next one
  task automatic run_cycle(bus_addr_t a, logic rd, logic wr, reg_byte_t d);
    addr     = a;
    read_en  = rd;
    write_en = wr;
    wdata    = d;
    // Halfway to the rising edge
    #1;
    compare_byte("rdata", model_read(a, rd), rdata);
    compare_irq("timer_irq", model_flags[2], timer_irq);
    model_step(a, wr, d);
    @(negedge clk);
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    int        wait_count;
    reg_byte_t tma_value;
    bus_addr_t mix_addr;
    logic      mix_rd;
    logic      mix_wr;
    reg_byte_t mix_data;
    clk      = 1'b0;
    reset    = 1'b1;
    addr     = '0;
    read_en  = 1'b0;
    write_en = 1'b0;
    wdata    = '0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Reset values, unmapped and idle reads
    run_cycle(ADDR_DIV, 1'b1, 1'b0, 8'h00);
    run_cycle(ADDR_TIMA, 1'b1, 1'b0, 8'h00);
    run_cycle(ADDR_TMA, 1'b1, 1'b0, 8'h00);
    run_cycle(ADDR_TAC, 1'b1, 1'b0, 8'h00);
    run_cycle(ADDR_IF, 1'b1, 1'b0, 8'h00);
    run_cycle(16'h1234, 1'b1, 1'b0, 8'h00);
    run_cycle(ADDR_TIMA, 1'b0, 1'b0, 8'h00);

    // Free-running DIV, restarted once midway
    for (int i = 0; i < DIV_CYCLES; i++) begin
      if (i == DIV_CYCLES / 2) run_cycle(ADDR_DIV, 1'b1, 1'b1, 8'hA5);
      else run_cycle(ADDR_DIV, 1'b1, 1'b0, 8'h00);
    end

    // All rates, enabled and disabled
    for (int rate = 0; rate < 4; rate++) begin
      for (int en = 0; en < 2; en++) begin
        run_cycle(ADDR_TAC, 1'b0, 1'b1, 8'(en * 4 + rate));
        run_cycle(ADDR_TIMA, 1'b0, 1'b1, 8'h00);
        repeat (RATE_CYCLES) run_cycle(ADDR_TIMA, 1'b1, 1'b0, 8'h00);
      end
    end

    // Disable while the selected bit is high
    run_cycle(ADDR_TAC, 1'b0, 1'b1, 8'h05);
    wait_count = 0;
    while (!(model_div[3] && model_prev) && wait_count < 40) begin
      run_cycle(ADDR_TIMA, 1'b1, 1'b0, 8'h00);
      wait_count++;
    end
    run_cycle(ADDR_TAC, 1'b0, 1'b1, 8'h01);
    repeat (4) run_cycle(ADDR_TIMA, 1'b1, 1'b0, 8'h00);

    // Overflow, reload on T1, then software clear
    repeat (4) begin
      tma_value = 8'(next_random());
      run_cycle(ADDR_TAC, 1'b0, 1'b1, 8'h05);
      run_cycle(ADDR_TMA, 1'b0, 1'b1, tma_value);
      run_cycle(ADDR_TIMA, 1'b0, 1'b1, 8'hFE);
      for (int i = 0; i < OVF_CYCLES; i++) begin
        run_cycle((i % 2 == 0) ? ADDR_TIMA : ADDR_IF, 1'b1, 1'b0, 8'h00);
      end
      run_cycle(ADDR_IF, 1'b1, 1'b1, 8'h00);
      run_cycle(ADDR_IF, 1'b1, 1'b0, 8'h00);
    end

    // Clear lands on the request cycle
    run_cycle(ADDR_TAC, 1'b0, 1'b1, 8'h05);
    run_cycle(ADDR_TIMA, 1'b0, 1'b1, 8'hFE);
    for (int i = 0; i < OVF_CYCLES; i++) begin
      run_cycle(ADDR_IF, 1'b1, model_req, 8'h00);
    end
    run_cycle(ADDR_IF, 1'b1, 1'b1, 8'h00);

    // Random traffic
    repeat (MIX_CYCLES) begin
      mix_addr = pick_addr();
      mix_rd   = (next_random() % 4) != 0;
      mix_wr   = (next_random() % 8) == 0;
      mix_data = 8'(next_random());
      run_cycle(mix_addr, mix_rd, mix_wr, mix_data);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/gb_timer_pkg.sv
verilog/t_phase_sequencer.sv
verilog/timer_reg_decode.sv
verilog/timer_core.sv
verilog/timer_interrupt_flag.sv
verilog/timer_subsystem.sv
dv/timer_subsystem_tb.sv
